// ==== Bender.yml ====
package:
  name: rom_loader

export_include_dirs:
  - verilog

sources:
  - verilog/rom_loader_pkg.sv
  - verilog/mem_write_if.sv
  - verilog/ines_parser.sv
  - verilog/write_queue.sv
  - verilog/slot_writer.sv
  - verilog/rom_loader.sv
  - target: test
    files:
      - testbench/rom_loader_asserts.sv
      - testbench/rom_loader_tb.sv

// ==== project.f ====
+incdir+verilog
verilog/rom_loader_pkg.sv
verilog/mem_write_if.sv
verilog/ines_parser.sv
verilog/write_queue.sv
verilog/slot_writer.sv
verilog/rom_loader.sv
testbench/rom_loader_asserts.sv
testbench/rom_loader_tb.sv

// ==== testbench/rom_loader_asserts.sv ====
// Slot writer checks
// Commit timing, handshake order and strobe spacing of the memory slot writer
`include "rom_loader_config.svh"

module rom_loader_asserts (
	input logic                                 clk,
	input logic                                 reset_nes,
	input logic                                 mem_we,
	input logic [$clog2(`MEM_SLOT_PERIOD)-1:0] slot_cnt,
	input logic                                 req,
	input logic                                 ack
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int LAST_SLOT = `MEM_SLOT_PERIOD - 1;

	int assert_failures = 0; // Failed assertion count

	// Strobe only on the final count of a slot
	we_on_last_slot: assert property (@(posedge clk) disable iff (reset_nes)
		mem_we |-> slot_cnt == LAST_SLOT)
		else begin
			assert_failures++;
			$error("mem_we seen outside the last slot count");
		end

	ack_needs_req: assert property (@(posedge clk) disable iff (reset_nes)
		$rose(ack) |-> req)
		else begin
			assert_failures++;
			$error("ack rose without a pending req");
		end

	// One commit per slot at most
	we_spacing: assert property (@(posedge clk) disable iff (reset_nes)
		mem_we |=> !mem_we [*LAST_SLOT])
		else begin
			assert_failures++;
			$error("Two mem_we pulses closer than one memory slot");
		end

endmodule

// ==== testbench/rom_loader_tb.sv ====
// ROM loader testbench
// Streams iNES images from the test data file, checks writes, flags and status
`include "rom_loader_config.svh"

module rom_loader_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import rom_loader_pkg::*;

	localparam int    REC_WORDS   = 20; // Header, invert, seed, flags, error
	localparam int    MAX_RECORDS = 16;
	localparam int    TRAIL_BYTES = 8;  // Sent after a rejected header
	localparam string DATA_FILE   = "testbench/rom_loader_testdata.txt";

	logic          clk;
	logic          reset_nes;
	logic          byte_req;
	logic [7:0]    byte_data;
	logic          invert_mirroring;
	logic          byte_ack;
	mem_addr_t     mem_addr;
	logic [7:0]    mem_data;
	logic          mem_we;
	mapper_flags_t mapper_flags;
	logic          busy;
	logic          done;
	logic          error;

	logic [31:0] testdata [MAX_RECORDS*REC_WORDS];
	int          num_records;
	int          value_errors;
	int          other_errors;
	longint      cycle_count;
	longint      cycle_limit;

	// Expected write stream of the running record
	int         exp_len;
	int         prg_len;
	logic [7:0] pay_seed;
	int         wr_count;
	logic       done_seen;
	logic       chr_empty;

	rom_loader rom_loader_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.byte_req         (byte_req),
		.byte_data        (byte_data),
		.invert_mirroring (invert_mirroring),
		.byte_ack         (byte_ack),
		.mem_addr         (mem_addr),
		.mem_data         (mem_data),
		.mem_we           (mem_we),
		.mapper_flags     (mapper_flags),
		.busy             (busy),
		.done             (done),
		.error            (error)
	);

	bind slot_writer rom_loader_asserts slot_asserts_i (
		.clk       (clk),
		.reset_nes (reset_nes),
		.mem_we    (mem_we),
		.slot_cnt  (slot_cnt),
		.req       (wr.req),
		.ack       (wr.ack)
	);

	always #5 clk = ~clk;

	task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_data(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_flags(input string name, input mapper_flags_t got,
			input mapper_flags_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic int assertion_failures();
		return rom_loader_i.writer_i.slot_asserts_i.assert_failures;
	endfunction

	// Bytes streamed after the header; a rejected image gets a short tail
	function automatic int payload_bytes(input int rec);
		if (testdata[rec*REC_WORDS + 19][0])
			return TRAIL_BYTES;
		return (int'(testdata[rec*REC_WORDS + 4][7:0]) << `PRG_PAGE_SHIFT)
			+ (int'(testdata[rec*REC_WORDS + 5][7:0]) << `CHR_PAGE_SHIFT);
	endfunction

	function automatic mem_addr_t expected_addr(input int index);
		if (index < prg_len)
			return mem_addr_t'(index);
		return mem_addr_t'(`CHR_BASE_ADDR + (index - prg_len)); // CHR follows PRG
	endfunction

	// Memory write monitor
	always @(posedge clk) begin
		if (!reset_nes && mem_we === 1'b1) begin
			if (wr_count >= exp_len) begin
				other_errors++;
				$display("Unexpected memory write to 0x%h beyond %0d expected writes",
					mem_addr, exp_len);
			end else begin
				check_addr("mem_addr", mem_addr, expected_addr(wr_count));
				check_data("mem_data", mem_data, pay_seed + 8'(wr_count));
				check_bit("busy", busy, 1'b1); // Payload still in flight
			end
			if (chr_empty && mem_addr >= `CHR_BASE_ADDR) begin
				other_errors++;
				$display("CHR area written although the image has no CHR pages");
			end
			wr_count++;
		end
		if (!reset_nes && done === 1'b1 && !done_seen) begin
			done_seen = 1'b1;
			if (wr_count != exp_len) begin
				other_errors++;
				$display("done rose with %0d of %0d memory writes committed", wr_count, exp_len);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			other_errors++;
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Closing: %0d value errors, %0d other errors, %0d assertion failures",
				value_errors, other_errors, assertion_failures());
			$display("Verification failed");
			$finish;
		end
	end

	task automatic load_testdata();
		foreach (testdata[i])
			testdata[i] = 32'hFFFF_FFFF; // Marks the end of the records
		$readmemh(DATA_FILE, testdata);
		num_records = 0;
		cycle_limit = 1000;
		while (num_records < MAX_RECORDS
				&& testdata[num_records*REC_WORDS] !== 32'hFFFF_FFFF) begin
			cycle_limit += (`INES_HEADER_BYTES + payload_bytes(num_records))
				* (8 + `MEM_SLOT_PERIOD);
			num_records++;
		end
		if (num_records == 0) begin
			other_errors++;
			$display("No test records found in %s", DATA_FILE);
		end
	endtask

	// Four-phase byte transfer after a random idle gap
	task automatic send_byte(input logic [7:0] value);
		int gap;
		gap = $urandom % 8;
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
		byte_data = value;
		byte_req  = 1'b1;
		do @(posedge clk); while (byte_ack !== 1'b1);
		#1 byte_req = 1'b0;
		do @(posedge clk); while (byte_ack !== 1'b0);
		#1;
	endtask

	task automatic run_record(input int rec);
		int            base;
		int            sent;
		logic          exp_error;
		mapper_flags_t exp_flags;
		base      = rec * REC_WORDS;
		exp_error = testdata[base + 19][0];
		exp_flags = testdata[base + 18];
		reset_nes = 1'b1;
		byte_req  = 1'b0;
		byte_data = 8'h00;
		invert_mirroring = testdata[base + 16][0];
		pay_seed  = testdata[base + 17][7:0];
		prg_len   = exp_error ? 0 : int'(testdata[base + 4][7:0]) << `PRG_PAGE_SHIFT;
		exp_len   = exp_error ? 0 : payload_bytes(rec);
		sent      = payload_bytes(rec);
		chr_empty = (testdata[base + 5][7:0] == 8'h00);
		wr_count  = 0;
		done_seen = 1'b0;
		repeat (10) @(posedge clk);
		#1 reset_nes = 1'b0;
		check_bit("byte_ack", byte_ack, 1'b0);
		check_bit("mem_we", mem_we, 1'b0);
		check_bit("busy", busy, 1'b0);
		check_bit("done", done, 1'b0);
		check_bit("error", error, 1'b0);

		for (int i = 0; i < `INES_HEADER_BYTES; i++)
			send_byte(testdata[base + i][7:0]);
		for (int i = 0; i < sent; i++)
			send_byte(pay_seed + 8'(i));
		while (done !== 1'b1)
			@(posedge clk);
		repeat (2) @(posedge clk);
		#1;
		check_bit("error", error, exp_error);
		check_bit("busy", busy, 1'b0);
		check_flags("mapper_flags", mapper_flags, exp_flags);
		if (wr_count != exp_len) begin
			other_errors++;
			$display("Record %0d: %0d memory writes seen, %0d expected", rec, wr_count, exp_len);
		end
	endtask

	initial begin
		clk              = 1'b0;
		reset_nes        = 1'b1;
		byte_req         = 1'b0;
		byte_data        = 8'h00;
		invert_mirroring = 1'b0;
		value_errors     = 0;
		other_errors     = 0;
		cycle_count      = 0;
		wr_count         = 0;
		done_seen        = 1'b0;
		exp_len          = 0;
		prg_len          = 0;
		pay_seed         = 8'h00;
		chr_empty        = 1'b0;
		void'($urandom(32'h463a_0a81));
		load_testdata();

		for (int r = 0; r < num_records; r++)
			run_record(r);

		$display("Closing: %0d value errors, %0d other errors, %0d assertion failures",
			value_errors, other_errors, assertion_failures());
		if (value_errors + other_errors + assertion_failures() == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== testbench/rom_loader_testdata.txt ====
// Per line: iNES header bytes 0..15, invert_mirroring, payload seed,
// expected mapper_flags, expected error bit
4E 45 53 1A 01 01 41 00 00 00 00 00 00 00 00 00 0 5A 00004004 0
4E 45 53 1A 01 00 B0 18 05 00 07 00 00 00 00 00 1 C3 000AC01B 0
4E 45 53 1A 00 01 20 40 00 00 00 00 44 00 00 00 0 17 00000002 0
4E 45 53 00 03 05 01 00 00 00 00 00 00 00 00 00 0 80 00005A00 1
4E 45 53 1A C8 64 0C 30 00 00 00 00 00 00 00 00 1 E1 00017F30 1

// ==== verilog/ines_parser.sv ====
// iNES image parser
// Collects the 16-byte header, validates it, builds the mapper flag word
// and turns the PRG and CHR payload into memory writes
`include "rom_loader_config.svh"

module ines_parser (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          byte_req,
	input  logic [7:0]                    byte_data,
	input  logic                          invert_mirroring,
	input  logic                          queue_drained,
	output logic                          byte_ack,
	output rom_loader_pkg::mapper_flags_t mapper_flags,
	output logic                          busy,
	output logic                          done,
	output logic                          error,
	mem_write_if.producer                 wr
);
	import rom_loader_pkg::*;

	localparam int HDR_LEN   = `INES_HEADER_BYTES;
	localparam int HDR_IDX_W = $clog2(HDR_LEN);
	localparam int HDR_CNT_W = $clog2(HDR_LEN + 1);

	loader_state_e        state;
	logic [7:0]           ines [HDR_LEN];
	logic [HDR_CNT_W-1:0] hdr_cnt;
	mem_addr_t            bytes_left;
	mem_addr_t            wr_addr;

	logic byte_take, hdr_take, issue, discard;
	logic magic_ok, is_nes20, is_dirty;

	// Smallest n with pages <= 2^n, clamped to 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int n = 6; n >= 0; n--) begin
			if (pages <= (9'd1 << n))
				code = 3'(n);
		end
		return code;
	endfunction

	assign byte_take = byte_req && !byte_ack;
	assign hdr_take  = (state == ST_HEADER) && (hdr_cnt != HDR_CNT_W'(HDR_LEN)) && byte_take;
	assign issue     = (state == ST_PRG || state == ST_CHR) && (bytes_left != '0)
			&& byte_take && !wr.req && !wr.ack;
	assign discard   = (state == ST_ERROR || state == ST_DONE) && byte_take;

	assign magic_ok = ({ines[0], ines[1], ines[2], ines[3]} == MAGIC_INES);
	assign is_nes20 = (ines[7][3:2] == 2'b10);
	assign is_dirty = !is_nes20 && ((|ines[9][7:1])
			|| (|{ines[10], ines[11], ines[12], ines[13], ines[14], ines[15]}));

	always_comb begin
		mapper_flags             = '0;
		mapper_flags.mapper      = {is_dirty ? 4'h0 : ines[7][7:4], ines[6][7:4]};
		mapper_flags.submapper   = is_nes20 ? ines[8] : 8'h00;
		mapper_flags.four_screen = ines[6][3];
		mapper_flags.chr_ram     = (ines[5] == 8'h00);
		mapper_flags.mirroring   = ines[6][0] ^ invert_mirroring;
		mapper_flags.chr_size    = size_code(ines[5]);
		mapper_flags.prg_size    = size_code(ines[4]);
	end

	// Header bytes and write payload
	always_ff @(posedge clk) begin
		if (hdr_take)
			ines[hdr_cnt[HDR_IDX_W-1:0]] <= byte_data;
		if (issue) begin
			wr.addr <= wr_addr;
			wr.data <= byte_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= ST_HEADER;
			hdr_cnt    <= '0;
			bytes_left <= '0;
			wr_addr    <= '0;
			byte_ack   <= 1'b0;
			wr.req     <= 1'b0;
			busy       <= 1'b0;
			done       <= 1'b0;
			error      <= 1'b0;
		end else begin
			if (!byte_req && byte_ack)
				byte_ack <= 1'b0; // Source has let go
			if (hdr_take || discard)
				byte_ack <= 1'b1;
			if (issue)
				wr.req <= 1'b1;
			if (wr.req && wr.ack) begin
				wr.req     <= 1'b0;
				byte_ack   <= 1'b1; // Byte is safely queued
				wr_addr    <= wr_addr + 1'b1;
				bytes_left <= bytes_left - 1'b1;
			end

			case (state)
				ST_HEADER: begin
					if (hdr_take)
						hdr_cnt <= hdr_cnt + 1'b1;
					if (hdr_cnt == HDR_CNT_W'(HDR_LEN)) begin
						if (magic_ok && !ines[6][2]) begin // Trainers unsupported
							state      <= ST_PRG;
							busy       <= 1'b1;
							wr_addr    <= '0;
							bytes_left <= mem_addr_t'(ines[4]) << `PRG_PAGE_SHIFT;
						end else begin
							state <= ST_ERROR;
						end
					end
				end
				ST_PRG: if (bytes_left == '0 && !wr.req) begin
					state      <= ST_CHR;
					wr_addr    <= `CHR_BASE_ADDR;
					bytes_left <= mem_addr_t'(ines[5]) << `CHR_PAGE_SHIFT;
				end
				ST_CHR: if (bytes_left == '0 && !wr.req && queue_drained) begin
					state <= ST_DONE;
					done  <= 1'b1;
					busy  <= 1'b0;
				end
				ST_ERROR: begin
					done  <= 1'b1;
					error <= 1'b1;
					busy  <= 1'b0;
				end
				default: ; // Done, bytes are dropped
			endcase
		end
	end

endmodule

// ==== verilog/mem_write_if.sv ====
// Memory write channel
// One address/data pair per transfer, four-phase req/ack handshake
interface mem_write_if;
	import rom_loader_pkg::*;

	logic      req;
	logic      ack;
	mem_addr_t addr; // Stable from req rise until ack rise
	logic [7:0] data;

	modport producer (
		output req,
		output addr,
		output data,
		input  ack
	);

	modport consumer (
		input  req,
		input  addr,
		input  data,
		output ack
	);

endinterface

// ==== verilog/rom_loader.sv ====
// ROM loader top level
// Byte stream in, slot-aligned console memory writes and mapper flags out
module rom_loader (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          byte_req,
	input  logic [7:0]                    byte_data,
	input  logic                          invert_mirroring,
	output logic                          byte_ack,
	output rom_loader_pkg::mem_addr_t     mem_addr,
	output logic [7:0]                    mem_data,
	output logic                          mem_we,
	output rom_loader_pkg::mapper_flags_t mapper_flags,
	output logic                          busy,
	output logic                          done,
	output logic                          error
);

	mem_write_if parser_wr ();
	mem_write_if queue_wr ();

	logic queue_drained;

	ines_parser parser_i (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.byte_req         (byte_req),
		.byte_data        (byte_data),
		.invert_mirroring (invert_mirroring),
		.queue_drained    (queue_drained),
		.byte_ack         (byte_ack),
		.mapper_flags     (mapper_flags),
		.busy             (busy),
		.done             (done),
		.error            (error),
		.wr               (parser_wr.producer)
	);

	write_queue queue_i (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.queue_drained (queue_drained),
		.in            (parser_wr.consumer),
		.out           (queue_wr.producer)
	);

	slot_writer writer_i (
		.clk       (clk),
		.reset_nes (reset_nes),
		.mem_addr  (mem_addr),
		.mem_data  (mem_data),
		.mem_we    (mem_we),
		.wr        (queue_wr.consumer)
	);

endmodule

// ==== verilog/rom_loader_config.svh ====
// ROM loader configuration
// Address width, iNES header layout, page sizes, queue depth and slot timing
`ifndef ROM_LOADER_CONFIG_SVH
`define ROM_LOADER_CONFIG_SVH

// Console memory map
`define LOADER_ADDR_W 22
`define CHR_BASE_ADDR 22'h20_0000 // CHR data lives above bit 21

// iNES file layout
`define INES_HEADER_BYTES 16
`define PRG_PAGE_SHIFT 14 // 16 KiB PRG pages
`define CHR_PAGE_SHIFT 13 // 8 KiB CHR pages

// Write path
`define WRITE_QUEUE_DEPTH 4
`define MEM_SLOT_PERIOD 4 // Console core runs every fourth clock

`endif

// ==== verilog/rom_loader_pkg.sv ====
// ROM loader types
// Parser states, image magic word and the mapper flag word seen by the core
`include "rom_loader_config.svh"

package rom_loader_pkg;

	typedef enum logic [2:0] {
		ST_HEADER,
		ST_PRG,
		ST_CHR,
		ST_ERROR,
		ST_DONE
	} loader_state_e;

	// "NES" followed by MS-DOS end of file
	typedef enum logic [31:0] {
		MAGIC_INES = 32'h4E45_531A
	} image_magic_e;

	typedef struct packed {
		logic [6:0] pad;
		logic [7:0] submapper;   // NES 2.0 only
		logic       four_screen;
		logic       chr_ram;     // No CHR ROM in the image
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef logic [`LOADER_ADDR_W-1:0] mem_addr_t;

endpackage

// ==== verilog/slot_writer.sv ====
// Memory slot writer
// Free-running slot counter; one queued write is committed per memory slot
`include "rom_loader_config.svh"

module slot_writer (
	input  logic                      clk,
	input  logic                      reset_nes,
	output rom_loader_pkg::mem_addr_t mem_addr,
	output logic [7:0]                mem_data,
	output logic                      mem_we,
	mem_write_if.consumer             wr
);

	localparam int PERIOD = `MEM_SLOT_PERIOD;
	localparam int SLOT_W = $clog2(PERIOD);

	logic [SLOT_W-1:0] slot_cnt, slot_next;
	logic commit;

	assign slot_next = (slot_cnt == SLOT_W'(PERIOD - 1)) ? '0 : slot_cnt + 1'b1;

	// Registered so mem_we and ack land on the last count
	assign commit = (slot_next == SLOT_W'(PERIOD - 1)) && wr.req && !wr.ack;

	always_ff @(posedge clk) begin
		if (commit) begin
			mem_addr <= wr.addr;
			mem_data <= wr.data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			slot_cnt <= '0;
			mem_we   <= 1'b0;
			wr.ack   <= 1'b0;
		end else begin
			slot_cnt <= slot_next;
			mem_we   <= commit; // Single-cycle strobe
			if (commit)
				wr.ack <= 1'b1;
			else if (!wr.req)
				wr.ack <= 1'b0;
		end
	end

endmodule

// ==== verilog/write_queue.sv ====
// Memory write queue
// Small FIFO of address/data pairs with a four-phase handshake on each side
`include "rom_loader_config.svh"

module write_queue (
	input  logic          clk,
	input  logic          reset_nes,
	output logic          queue_drained,
	mem_write_if.consumer in,
	mem_write_if.producer out
);
	import rom_loader_pkg::*;

	localparam int DEPTH = `WRITE_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	mem_addr_t  addr_mem [DEPTH];
	logic [7:0] data_mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic push, pop, launch;

	assign push   = in.req && !in.ack && (count != CNT_W'(DEPTH)); // Waits when full
	assign pop    = out.req && out.ack;
	assign launch = !out.req && !out.ack && (count != '0);

	assign queue_drained = (count == '0) && !out.req && !out.ack;

	always_ff @(posedge clk) begin
		if (push) begin
			addr_mem[wr_ptr] <= in.addr;
			data_mem[wr_ptr] <= in.data;
		end
		if (launch) begin
			out.addr <= addr_mem[rd_ptr];
			out.data <= data_mem[rd_ptr];
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count   <= '0;
			in.ack  <= 1'b0;
			out.req <= 1'b0;
		end else begin
			if (push) begin
				in.ack <= 1'b1;
				wr_ptr <= wr_ptr + 1'b1;
			end else if (!in.req) begin
				in.ack <= 1'b0;
			end

			if (launch)
				out.req <= 1'b1;
			if (pop) begin
				out.req <= 1'b0;
				rd_ptr  <= rd_ptr + 1'b1; // Entry leaves only once committed
			end

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule
